//--- program.hex
// Test program, one instruction word per line starting at word 0
// Fields are class[31:30] op[29:26] rd[25:23] ra[22:20] rb[19:17] imm[15:0]
04800007 // w0  addi r1, r0, 7
0500000C // w1  addi r2, r0, 12
01940000 // w2  add  r3, r1, r2
84060004 // w3  sw   r3 -> word 4
06000BAD // w4  addi r4, r0, marker
40000001 // w5  b    w7
84080007 // w6  sw   r4 -> word 7, skipped
82800004 // w7  lw   r5 <- word 4
07500001 // w8  addi r6, r5, 1
840C0005 // w9  sw   r6 -> word 5
44100001 // w10 beqz r1, w12, not taken
84040006 // w11 sw   r2 -> word 6
07800004 // w12 addi r7, r0, 4
840E0008 // w13 sw   r7 -> word 8, loop head
07F0FFFF // w14 addi r7, r7, -1
44700001 // w15 beqz r7, w17
4000FFFC // w16 b    w13
4000FFFF // w17 b    w17, parks the core

//--- verilog.f
+incdir+.
cpu_pkg.sv
fetch_exec_if.sv
instr_mem.sv
fetch_unit.sv
exec_unit.sv
cpu_top.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - fetch_exec_if.sv
      - instr_mem.sv
      - fetch_unit.sv
      - exec_unit.sv
      - cpu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu
  import cpu_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int PROG_WORDS   = 18;                  // Words in program.hex
  localparam int STOP_LIMIT   = `CPU_STOP_FLUSH + 6; // Run low to stopped, worst case
  localparam int GAP_MIN      = 3;                   // Running cycles before each pause
  localparam int GAP_MAX      = 12;
  localparam int HOLD_MIN     = 2;                   // Cycles spent stopped
  localparam int HOLD_MAX     = 6;
  localparam int MAX_PAUSES   = 4;
  localparam int TAIL_CYCLES  = 20;                  // Quiet time after the last store
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_WORDS * 8 + TAIL_CYCLES +
                                   MAX_PAUSES * (GAP_MAX + STOP_LIMIT + HOLD_MAX);
  localparam word_t MARKER = 32'h0000_0bad; // Only the store behind the taken branch holds it

  localparam int T_RESET = 0;
  localparam int T_ALU   = 1;
  localparam int T_LOAD  = 2;
  localparam int T_FALL  = 3;
  localparam int T_LOOP  = 4;
  localparam int T_SKIP  = 5;
  localparam int T_STOP  = 6;
  localparam int T_SEQ   = 7;
  localparam int NUM_TESTS = 8;

  logic       clk;
  logic       reset;
  logic       run;
  logic       stopped;
  logic       store_valid;
  dmem_addr_t store_addr;
  word_t      store_data;

  integer seed;
  int     errors = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     stores_seen = 0;
  int     pauses = 0;
  int     test_err [NUM_TESTS];

  // Expected stores in program order, with the test that each one belongs to
  int         exp_test [$];
  dmem_addr_t exp_addr [$];
  word_t      exp_data [$];

  cpu_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .stopped     (stopped),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Bookkeeping
  ////////////////////

  function automatic string test_name(input int idx);
    case (idx)
      T_RESET: return "reset state";
      T_ALU:   return "add and add-immediate sum stored";
      T_LOAD:  return "load returns stored word";
      T_FALL:  return "not-taken branch falls through";
      T_LOOP:  return "countdown loop stores";
      T_SKIP:  return "taken branch skips marker store";
      T_STOP:  return "stop and resume";
      default: return "store sequence complete";
    endcase
  endfunction

  task automatic count_error(input int idx);
    test_err[idx]++;
    errors++;
  endtask

  task automatic report_test(input int idx);
    tests_run++;
    if (test_err[idx] == 0) begin
      $display("Test %0d %s: ok", idx, test_name(idx));
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAILED with %0d errors", idx, test_name(idx), test_err[idx]);
    end
  endtask

  task automatic add_store(input int idx, input dmem_addr_t addr, input word_t data);
    exp_test.push_back(idx);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // Worked out by hand from the instruction rules and program.hex
  task automatic load_expected();
    add_store(T_ALU, 6'd4, 32'd19);  // r1 = 7 and r2 = 12 by addi, r3 = r1 + r2
    // w5 jumps over w6, so the marker is never stored
    add_store(T_LOAD, 6'd5, 32'd20); // Word 4 loaded into r5, plus 1
    add_store(T_FALL, 6'd6, 32'd12); // r1 is 7 so beqz falls through to the r2 store
    for (int n = 4; n >= 1; n--) begin
      add_store(T_LOOP, 6'd8, word_t'(n)); // Stored before each decrement, exits at zero
    end
  endtask

  ////////////////////
  // Store checking
  ////////////////////

  task automatic check_store();
    int         idx;
    dmem_addr_t want_addr;
    word_t      want_data;
    assert (store_data !== MARKER) else begin
      $display("[ERROR] %0t store_data: expected anything but %h, got %h",
               $time, MARKER, store_data);
      count_error(T_SKIP);
    end
    if (exp_data.size() == 0) begin
      $display("Store of %h to word %0d at %0t came after the expected sequence ended",
               store_data, store_addr, $time);
      count_error(T_SEQ);
    end else begin
      idx       = exp_test.pop_front();
      want_addr = exp_addr.pop_front();
      want_data = exp_data.pop_front();
      stores_seen++;
      assert (store_addr === want_addr) else begin
        $display("[ERROR] %0t store_addr: expected %0d, got %0d", $time, want_addr, store_addr);
        count_error(idx);
      end
      assert (store_data === want_data) else begin
        $display("[ERROR] %0t store_data: expected %h, got %h", $time, want_data, store_data);
        count_error(idx);
      end
      if ((exp_test.size() == 0) || (exp_test[0] != idx)) begin
        report_test(idx); // Last store of its group
      end
    end
  endtask

  // Outputs are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (!reset) begin
      assert (!(stopped && store_valid)) else begin
        $display("Store to word %0d at %0t while the core reported stopped", store_addr, $time);
        count_error(T_STOP);
      end
      if (store_valid) begin
        check_store();
      end
    end
  end

  ////////////////////
  // Run control
  ////////////////////

  task automatic pause_and_resume();
    int gap;
    int hold;
    int cycles;
    gap    = GAP_MIN + ({$random(seed)} % (GAP_MAX - GAP_MIN + 1));
    hold   = HOLD_MIN + ({$random(seed)} % (HOLD_MAX - HOLD_MIN + 1));
    cycles = 0;
    repeat (gap) @(posedge clk);
    run <= 1'b0;
    while ((stopped !== 1'b1) && (cycles < STOP_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    assert (stopped === 1'b1) else begin
      $display("stopped did not rise within %0d cycles of run going low, at %0t",
               STOP_LIMIT, $time);
      count_error(T_STOP);
    end
    pauses++;
    repeat (hold) @(posedge clk);
    run <= 1'b1; // Fetch picks up at the held PC
  endtask

  initial begin
    seed  = 32'h3838;
    reset = 1'b1;
    run   = 1'b1;
    for (int i = 0; i < NUM_TESTS; i++) begin
      test_err[i] = 0;
    end
    load_expected();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (stopped === 1'b0) else begin
      $display("[ERROR] %0t stopped: expected 0, got %b", $time, stopped);
      count_error(T_RESET);
    end
    assert (store_valid === 1'b0) else begin
      $display("[ERROR] %0t store_valid: expected 0, got %b", $time, store_valid);
      count_error(T_RESET);
    end
    report_test(T_RESET);

    // Pauses only while stores are still pending, so each resume is checked by the queue
    for (int p = 0; p < MAX_PAUSES; p++) begin
      if (exp_data.size() != 0) begin
        pause_and_resume();
      end
    end
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
    repeat (TAIL_CYCLES) @(negedge clk); // Core parks on w17, no store may follow

    report_test(T_SKIP);
    report_test(T_STOP);
    report_test(T_SEQ);
    $display("Tests: %0d run, %0d failed, %0d errors, %0d stores checked, %0d pauses",
             tests_run, tests_failed, errors, stores_seen, pauses);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Covers the program at 8 cycles per word plus every pause at its longest
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with %0d stores still pending",
             WATCHDOG_CYCLES, exp_data.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       run,   // Low requests a drain to stopped
  output logic       stopped,
  output logic       store_valid,
  output dmem_addr_t store_addr,
  output word_t      store_data
);

  //////////////////////
  // Internal buses
  //////////////////////

  fetch_exec_if fx ();   // Instructions forward, stall release and targets back
  imem_if       imem (); // Fetch address out, ROM word back one cycle later

  //////////////////////
  // Front end
  //////////////////////

  fetch_unit u_fetch (
    .clk     (clk),
    .reset   (reset),
    .run     (run),
    .stopped (stopped),
    .imem    (imem.fetch),
    .fx      (fx.fetch)
  );

  instr_mem u_imem (
    .clk  (clk),
    .imem (imem.memory)
  );

  //////////////////////
  // Back end
  //////////////////////

  exec_unit u_exec (
    .clk         (clk),
    .reset       (reset),
    .fx          (fx.exec),
    .store_valid (store_valid), // One pulse per executed store
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

endmodule

`default_nettype wire

//--- exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module exec_unit
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  fetch_exec_if.exec fx,
  output logic       store_valid,
  output dmem_addr_t store_addr,
  output word_t      store_data
);

  localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

  // Decoded fields of the presented instruction
  instr_class_t cls;
  logic [3:0]   opcode;
  reg_idx_t     rd;
  reg_idx_t     ra;
  reg_idx_t     rb;
  word_t        imm; // Sign extended
  word_t        ra_val;
  word_t        rb_val;

  word_t rf [0:NUM_REGS-1];         // Entry 0 is never written
  word_t dmem [0:`CPU_DMEM_WORDS-1];

  exec_state_t state;

  word_t      alu_result;
  word_t      branch_target;
  logic       take_branch;
  word_t      mem_sum;
  dmem_addr_t mem_addr;

  // Registered results towards fetch
  logic  stall_clear_q;
  logic  branch_taken_q;
  word_t branch_pc_q;

  // Memory instruction held across mem_access and mem_done
  dmem_addr_t mem_addr_q;
  word_t      mem_wdata_q;
  logic       mem_load_q;
  logic       mem_store_q;
  reg_idx_t   mem_rd_q;
  word_t      load_q;

  // Register file write port
  logic     rf_we;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;

  //////////////////////
  // Decode
  //////////////////////

  assign cls    = instr_class_t'(fx.instr[31:30]);
  assign opcode = fx.instr[29:26];
  assign rd     = fx.instr[25:23];
  assign ra     = fx.instr[22:20];
  assign rb     = fx.instr[19:17];
  assign imm    = {{16{fx.instr[15]}}, fx.instr[15:0]};

  assign ra_val = (ra == 3'd0) ? 32'd0 : rf[ra]; // r0 is hard wired to zero
  assign rb_val = (rb == 3'd0) ? 32'd0 : rf[rb];

  //////////////////////
  // ALU and branch
  //////////////////////

  assign alu_result = (opcode == 4'd1) ? ra_val + imm : ra_val + rb_val; // addi / add

  // Targets are relative to the instruction after the branch, in words
  assign branch_target = fx.pc_plus_4 + {imm[29:0], 2'b00};
  assign take_branch   = (opcode == 4'd0) || ((opcode == 4'd1) && (ra_val == 32'd0));

  assign mem_sum  = ra_val + imm;
  assign mem_addr = mem_sum[$bits(dmem_addr_t)-1:0]; // Word index wraps at the depth

  //////////////////////
  // Sequencing
  //////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= idle;
      stall_clear_q  <= 1'b0;
      branch_taken_q <= 1'b0;
      store_valid    <= 1'b0;
    end else begin
      stall_clear_q  <= 1'b0; // All three are single cycle pulses
      branch_taken_q <= 1'b0;
      store_valid    <= 1'b0;
      case (state)
        idle: begin
          if (cls == branch) begin
            stall_clear_q  <= 1'b1; // Resolved at once, released next cycle
            branch_taken_q <= take_branch;
          end else if (cls == mem) begin
            state <= mem_access;
          end
        end
        mem_access: begin
          state         <= mem_done;
          stall_clear_q <= 1'b1;        // Fetch resumes during mem_done
          store_valid   <= mem_store_q;
        end
        default: begin
          state <= idle; // mem_done lasts one cycle
        end
      endcase
    end
  end

  // Operands captured at presentation, the following instructions are NOPs
  always_ff @(posedge clk) begin
    if ((state == idle) && (cls == branch)) begin
      branch_pc_q <= branch_target;
    end
    if ((state == idle) && (cls == mem)) begin
      mem_addr_q  <= mem_addr;
      mem_wdata_q <= rb_val;
      mem_load_q  <= (opcode == 4'd0);
      mem_store_q <= (opcode == 4'd1);
      mem_rd_q    <= rd;
    end
  end

  assign fx.stall_clear  = stall_clear_q;
  assign fx.branch_taken = branch_taken_q;
  assign fx.branch_pc    = branch_pc_q;

  //////////////////////
  // Data memory
  //////////////////////

  always_ff @(posedge clk) begin
    if (state == mem_access) begin
      if (mem_store_q) begin
        dmem[mem_addr_q] <= mem_wdata_q;
      end
      load_q <= dmem[mem_addr_q]; // Old contents, only used by loads
    end
  end

  assign store_addr = mem_addr_q; // Stable through mem_done
  assign store_data = mem_wdata_q;

  //////////////////////
  // Register write-back
  //////////////////////

  always_comb begin
    rf_we    = 1'b0;
    rf_waddr = rd;
    rf_wdata = alu_result;
    if ((state == mem_done) && mem_load_q) begin
      rf_we    = 1'b1;
      rf_waddr = mem_rd_q;
      rf_wdata = load_q;
    end else if ((state == idle) && (cls == alu) && (opcode <= 4'd1)) begin
      rf_we = 1'b1; // Result is visible to the next instruction
    end
  end

  always_ff @(posedge clk) begin
    if (rf_we && (rf_waddr != 3'd0)) begin
      rf[rf_waddr] <= rf_wdata;
    end
  end

  // Fetch only loads the target while it is also releasing the stall
  a_taken_with_clear: assert property (@(posedge clk) disable iff (reset)
    fx.branch_taken |-> fx.stall_clear)
    else $error("exec_unit: branch_taken without stall_clear");

  a_store_single: assert property (@(posedge clk) disable iff (reset)
    store_valid |=> !store_valid)
    else $error("exec_unit: store_valid held for more than one cycle");

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module fetch_unit
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        run,
  output logic        stopped,
  imem_if.fetch       imem,
  fetch_exec_if.fetch fx
);

  word_t        pc;          // Address of the instruction now presented
  word_t        next_pc;
  logic         fetch_valid; // Low for the first cycle out of reset
  logic         stalled;     // A branch or memory instruction is in flight
  logic         stalling;
  logic         stopping;    // Draining towards stopped
  logic [2:0]   stop_ctr;
  instr_class_t cur_class;

  //////////////////////
  // Next PC
  //////////////////////

  // PC relative targets are taken from here, not from the PC itself
  assign fx.pc_plus_4 = pc + 32'd4;

  assign next_pc = fx.branch_taken ? fx.branch_pc : fx.pc_plus_4; // Target only on a clear

  //////////////////////
  // Partial decode
  //////////////////////

  // During a stall or a drain the back end sees NOPs only
  assign fx.instr = (stalled || stopping || !fetch_valid) ? `CPU_INSTR_NOP : imem.fetch_data;

  assign cur_class = instr_class_t'(fx.instr[31:30]);

  // Branches and memory instructions hold fetch until the back end is done with them
  assign stalling = ((cur_class == branch) || (cur_class == mem) || stalled) &&
                    !fx.stall_clear;

  // Keep requesting the current PC while held, so the word is ready on resume
  assign imem.fetch_addr = (stalling || stopping || !run) ? pc : next_pc;

  //////////////////////
  // PC register
  //////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CPU_RESET_ADDR;
    end else if (!stalling && !stopping) begin
      pc <= next_pc; // Also takes the branch target in the stall_clear cycle
    end
  end

  // Out of reset the ROM still shows whatever was addressed during reset
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= 1'b1;
    end
  end

  //////////////////////
  // Stall and stop
  //////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      stalled  <= 1'b0;
      stopping <= 1'b0;
      stopped  <= 1'b0;
      stop_ctr <= `CPU_STOP_FLUSH;
    end else begin
      if (stalling) begin
        stalled <= 1'b1;
      end else if (fx.stall_clear) begin
        stalled <= 1'b0;
      end

      if (run) begin
        // Resume at the held PC on the next edge
        stopping <= 1'b0;
        stopped  <= 1'b0;
        stop_ctr <= `CPU_STOP_FLUSH;
      end else begin
        if (!stalling) begin
          stopping <= 1'b1; // Never stop in the middle of a branch or a memory access
        end
        if (stopping && (stop_ctr != 3'd0) && !stalling) begin
          stop_ctr <= stop_ctr - 3'd1; // Let earlier instructions leave the pipeline
        end
        if (stop_ctr == 3'd0) begin
          stopped <= 1'b1;
        end
      end
    end
  end

  // The back end only releases a stall that fetch is actually holding
  a_clear_needs_stall: assert property (@(posedge clk) disable iff (reset)
    fx.stall_clear |-> stalled)
    else $error("fetch_unit: stall_clear without a stall");

  // Once stopped, nothing but NOPs reaches the execute unit
  a_stopped_nop: assert property (@(posedge clk) disable iff (reset)
    stopped |-> (fx.instr == `CPU_INSTR_NOP))
    else $error("fetch_unit: instruction issued while stopped");

endmodule

`default_nettype wire

//--- instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module instr_mem
  import cpu_pkg::*;
(
  input logic   clk,
  imem_if.memory imem
);

  localparam int IDX_W = $clog2(`CPU_IMEM_WORDS);

  word_t rom [0:`CPU_IMEM_WORDS-1]; // Program image
  logic [IDX_W-1:0] word_idx;

  initial begin
    $readmemh("program.hex", rom);
  end

  // Byte address to word index, wrapping at the ROM depth
  assign word_idx = imem.fetch_addr[IDX_W+1:2];

  always_ff @(posedge clk) begin
    imem.fetch_data <= rom[word_idx]; // One cycle read latency
  end

  // Fetch only ever asks for words inside the program image, apart from the
  // reset PC, which can be presented while the core stops straight out of reset
  a_fetch_in_range: assert property (@(posedge clk)
    !$isunknown(imem.fetch_addr) |->
      (imem.fetch_addr[31:2] < `CPU_IMEM_WORDS) || (imem.fetch_addr == `CPU_RESET_ADDR))
    else $error("instr_mem: fetch address %h is beyond the ROM", imem.fetch_addr);

endmodule

`default_nettype wire

//--- fetch_exec_if.sv
`timescale 1ns/1ps
`default_nettype none

//////////////////////
// Fetch to execute
//////////////////////

interface fetch_exec_if
  import cpu_pkg::*;
();

  word_t instr;        // Instruction to execute, or the NOP during a stall
  word_t pc_plus_4;    // Address of the instruction after instr
  word_t branch_pc;    // Resolved branch target
  logic  branch_taken; // Single cycle, only together with stall_clear
  logic  stall_clear;  // Single cycle, releases the fetch stall

  modport fetch (output instr, pc_plus_4, input branch_pc, branch_taken, stall_clear);
  modport exec (input instr, pc_plus_4, output branch_pc, branch_taken, stall_clear);

endinterface

//////////////////////
// Instruction memory
//////////////////////

// The word requested in one cycle comes back in the next
interface imem_if
  import cpu_pkg::*;
();

  word_t fetch_addr; // Byte address, word aligned
  word_t fetch_data; // Registered ROM output

  modport fetch (output fetch_addr, input fetch_data);
  modport memory (input fetch_addr, output fetch_data);

endinterface

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

  // Data, address and instruction words all share one width
  typedef logic [31:0] word_t;

  typedef logic [2:0] reg_idx_t; // Eight architectural registers, r0 reads as zero

  // Word index into the data memory, low bits of ra + imm
  typedef logic [$clog2(`CPU_DMEM_WORDS)-1:0] dmem_addr_t;

  // Top two bits of every instruction
  typedef enum logic [1:0] {
    alu      = 2'b00, // Register writes, never stalls fetch
    branch   = 2'b01, // Stalls until the target is resolved
    mem      = 2'b10, // Loads and stores, stall until mem_done
    reserved = 2'b11 // Executes as a NOP
  } instr_class_t;

  // Execute unit sequencing for memory instructions
  typedef enum logic [1:0] {
    idle,       // Accepting a new instruction every cycle
    mem_access, // Data memory read or write
    mem_done    // Load write-back, store strobe and stall release
  } exec_state_t;

endpackage

`default_nettype wire

//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

//////////////////////
// Fetch side
//////////////////////

// The PC starts one word before address 0, so the first request goes to address 0
`define CPU_RESET_ADDR 32'hffff_fffc

`define CPU_INSTR_NOP 32'h0000_0000 // Class 00, opcode 0, add r0 = r0 + r0

`define CPU_STOP_FLUSH 3'd5 // Cycles of NOPs issued before the core reports stopped

//////////////////////
// Memory depths
//////////////////////

`define CPU_IMEM_WORDS 256 // Instruction ROM, in 32-bit words
`define CPU_DMEM_WORDS 64 // Internal data memory, in 32-bit words

`endif
